/* src/mem_defines.svh */
`ifndef MEM_DEFINES_SVH
`define MEM_DEFINES_SVH

// address and data path width, rv32 word
`define ADDR_W 32

// set index bits of the direct-mapped cache
// 3 bits give 8 lines of one word each
`define SET_BITS 3

// depth of the backing data ram in words
// word index sits just above the 2-bit byte offset
`define RAM_WORDS 256

`endif

/* src/mem_pkg.sv */
`include "mem_defines.svh"

package mem_pkg;

    // tag is everything above set index and byte offset
    localparam int TAG_W = `ADDR_W - `SET_BITS - 2;

    typedef enum logic [2:0] {
        W_BYTE  = 3'b000, // lb / sb
        W_HALF  = 3'b001, // lh / sh
        W_WORD  = 3'b010, // lw / sw
        W_BYTEU = 3'b100, // lbu
        W_HALFU = 3'b101  // lhu
    } mem_width_e;

    typedef struct packed {
        logic              en;    // access strobe
        logic              we;    // 1 = store, 0 = load
        mem_width_e        width; // size and signedness, funct3 coding
        logic [`ADDR_W-1:0] addr;  // byte address
        logic [`ADDR_W-1:0] wdata; // store data, low-aligned
    } mem_req_t;

    typedef struct packed {
        logic              strobe; // write this cycle
        logic [3:0]        mask;   // one bit per byte lane
        logic [`ADDR_W-1:0] data;   // data already shifted into its lanes
    } mem_wr_t;

    typedef struct packed {
        logic              valid;
        logic [TAG_W-1:0]  tag;
        logic [`ADDR_W-1:0] data;
    } cache_line_t;

endpackage

/* src/store_align.sv */
`timescale 1ns/1ps
`include "mem_defines.svh"

module store_align (
    input  mem_pkg::mem_req_t req_i,
    output mem_pkg::mem_wr_t  wr_o
);
    import mem_pkg::*;

    logic [1:0]         offset;    // byte offset inside the word
    logic [3:0]         mask;
    logic [`ADDR_W-1:0] lane_data;

    assign offset = req_i.addr[1:0];

    always_comb begin
        case (req_i.width)
            W_BYTE, W_BYTEU: begin
                mask      = 4'b0001 << offset;        // single lane
                lane_data = {4{req_i.wdata[7:0]}};    // byte copied to every lane
            end
            W_HALF, W_HALFU: begin
                mask      = offset[1] ? 4'b1100 : 4'b0011; // aligned half only
                lane_data = {2{req_i.wdata[15:0]}};
            end
            W_WORD: begin
                mask      = 4'b1111;
                lane_data = req_i.wdata;
            end
            default: begin
                mask      = 4'b0000;                  // unknown width writes nothing
                lane_data = req_i.wdata;
            end
        endcase
    end

    // strobe only for stores; loads leave ram and cache lanes untouched
    assign wr_o.strobe = req_i.en & req_i.we;
    assign wr_o.mask   = mask;
    assign wr_o.data   = lane_data;

endmodule

/* src/dcache.sv */
`timescale 1ns/1ps
`include "mem_defines.svh"

module dcache (
    input  logic                clk,
    input  logic                rst_i,
    input  mem_pkg::mem_req_t   req_i,
    input  mem_pkg::mem_wr_t    wr_i,
    input  logic [`ADDR_W-1:0]  ram_rdata_i,
    output logic [`ADDR_W-1:0]  word_o,
    output logic                hit_o
);
    import mem_pkg::*;

    localparam int LINES = 2 ** `SET_BITS;

    cache_line_t            lines [LINES];
    cache_line_t            cur_line;    // line selected by the set index
    logic [`SET_BITS-1:0]   set_idx;
    logic [TAG_W-1:0]       req_tag;
    logic                   lookup_hit;  // valid line with matching tag
    logic                   full_word;   // store covers all four lanes

    // address split [tag | set | offset]
    assign set_idx = req_i.addr[`SET_BITS+1:2];
    assign req_tag = req_i.addr[`ADDR_W-1:`SET_BITS+2];

    assign cur_line   = lines[set_idx];
    assign lookup_hit = cur_line.valid && (cur_line.tag == req_tag);
    assign full_word  = (wr_i.mask == 4'b1111);

    assign hit_o  = req_i.en & lookup_hit;
    assign word_o = lookup_hit ? cur_line.data : ram_rdata_i; // miss falls through to ram

    always_ff @(posedge clk) begin
        if (rst_i) begin
            for (int s = 0; s < LINES; s++) begin
                lines[s].valid <= 1'b0; // tag and data keep stale contents
            end
        end else if (req_i.en) begin
            if (wr_i.strobe) begin
                if (lookup_hit) begin
                    // write-through hit, keep the line in step with ram
                    for (int b = 0; b < 4; b++) begin
                        if (wr_i.mask[b]) begin
                            lines[set_idx].data[8*b +: 8] <= wr_i.data[8*b +: 8];
                        end
                    end
                end else if (full_word) begin
                    lines[set_idx].valid <= 1'b1; // sw miss allocates
                    lines[set_idx].tag   <= req_tag;
                    lines[set_idx].data  <= wr_i.data;
                end
                // partial store miss: line untouched, ram alone takes the bytes
            end else if (!lookup_hit) begin
                lines[set_idx].valid <= 1'b1; // load miss, fill from ram word
                lines[set_idx].tag   <= req_tag;
                lines[set_idx].data  <= ram_rdata_i;
            end
        end
    end

endmodule

/* src/data_ram.sv */
`timescale 1ns/1ps
`include "mem_defines.svh"

module data_ram (
    input  logic                clk,
    input  logic                rst_i,
    input  logic [`ADDR_W-1:0]  addr_i,
    input  mem_pkg::mem_wr_t    wr_i,
    output logic [`ADDR_W-1:0]  rdata_o
);

    localparam int IDX_W = $clog2(`RAM_WORDS); // word index bits

    logic [`ADDR_W-1:0] mem [`RAM_WORDS];
    logic [IDX_W-1:0]   idx;

    assign idx = addr_i[IDX_W+1:2]; // drop byte offset, upper bits wrap

    // byte-masked write on the edge, whole array cleared in reset
    always_ff @(posedge clk) begin
        if (rst_i) begin
            for (int w = 0; w < `RAM_WORDS; w++) begin
                mem[w] <= '0;
            end
        end else if (wr_i.strobe) begin
            for (int b = 0; b < 4; b++) begin
                if (wr_i.mask[b]) begin
                    mem[idx][8*b +: 8] <= wr_i.data[8*b +: 8]; // only masked lanes
                end
            end
        end
    end

    // asynchronous read, load miss data comes back in the same cycle
    assign rdata_o = mem[idx];

endmodule

/* src/load_extend.sv */
`timescale 1ns/1ps
`include "mem_defines.svh"

module load_extend (
    input  logic [`ADDR_W-1:0]  word_i,
    input  mem_pkg::mem_width_e width_i,
    input  logic [1:0]          offset_i,
    output logic [`ADDR_W-1:0]  data_o
);
    import mem_pkg::*;

    logic [7:0]  sel_byte; // addressed byte moved to bit 0
    logic [15:0] sel_half; // addressed half moved to bit 0

    assign sel_byte = word_i[8*offset_i +: 8];
    assign sel_half = offset_i[1] ? word_i[31:16] : word_i[15:0]; // halves are aligned

    always_comb begin
        case (width_i)
            W_BYTE: begin
                data_o = {{24{sel_byte[7]}}, sel_byte};  // lb
            end
            W_BYTEU: begin
                data_o = {24'b0, sel_byte};              // lbu
            end
            W_HALF: begin
                data_o = {{16{sel_half[15]}}, sel_half}; // lh
            end
            W_HALFU: begin
                data_o = {16'b0, sel_half};              // lhu
            end
            W_WORD: begin
                data_o = word_i;                         // lw
            end
            default: begin
                data_o = word_i;
            end
        endcase
    end

endmodule

/* src/mem_stage.sv */
`timescale 1ns/1ps
`include "mem_defines.svh"

module mem_stage (
    input  logic                clk,
    input  logic                rst_i,
    input  mem_pkg::mem_req_t   req_i,
    output logic [`ADDR_W-1:0]  load_data_o,
    output logic                hit_o
);
    import mem_pkg::*;

    mem_wr_t            wr;          // aligned store, feeds cache and ram
    logic [`ADDR_W-1:0] ram_rdata;   // ram word at the request address
    logic [`ADDR_W-1:0] raw_word;    // cache word on hit, ram word on miss
    logic [`ADDR_W-1:0] ext_word;
    logic               cache_hit;
    logic               load_active; // enabled load outside reset

    store_align u_store_align (
        .req_i (req_i),
        .wr_o  (wr)
    );

    dcache u_dcache (
        .clk         (clk),
        .rst_i       (rst_i),
        .req_i       (req_i),
        .wr_i        (wr),
        .ram_rdata_i (ram_rdata),
        .word_o      (raw_word),
        .hit_o       (cache_hit)
    );

    data_ram u_data_ram (
        .clk     (clk),
        .rst_i   (rst_i),
        .addr_i  (req_i.addr),
        .wr_i    (wr),
        .rdata_o (ram_rdata)
    );

    load_extend u_load_extend (
        .word_i   (raw_word),
        .width_i  (req_i.width),
        .offset_i (req_i.addr[1:0]),
        .data_o   (ext_word)
    );

    assign load_active = req_i.en & ~req_i.we & ~rst_i;

    // outputs stay quiet for idle cycles, stores and reset
    assign load_data_o = load_active ? ext_word : '0;
    assign hit_o       = load_active & cache_hit;

endmodule

/* tb/tb_clock.sv */
`timescale 1ns/1ps

module tb_clock #(
    parameter int PERIOD_NS = 10
) (
    output logic clk_o
);

    initial clk_o = 1'b0;                     // known level before the first edge

    always #(PERIOD_NS / 2) clk_o = ~clk_o;   // 50 % duty cycle

endmodule

/* tb/mem_stage_tb.sv */
`timescale 1ns/1ps
`include "mem_defines.svh"

module mem_stage_tb;
    import mem_pkg::*;

    localparam int CLK_PERIOD   = 10;
    localparam int RESET_CYCLES = 8;
    localparam int LINES        = 2 ** `SET_BITS;
    localparam int IDX_W        = $clog2(`RAM_WORDS);
    localparam int T1_LOADS     = 32;                // one cycle each
    localparam int T2_WORDS     = 8;                 // store + two loads each
    localparam int T3_CYCLES    = 6 * 7;             // 4 byte and 2 half rounds of 7
    localparam int T4_ROUNDS    = 6;                 // 6 accesses per round
    localparam int T5_ACCESSES  = 2000;
    localparam int T6_CYCLES    = RESET_CYCLES + 3;  // store, reset, release, load
    localparam int TOTAL_CYCLES = RESET_CYCLES + 2 + T1_LOADS + 3 * T2_WORDS + T3_CYCLES
                                + 6 * T4_ROUNDS + T5_ACCESSES + T6_CYCLES;
    localparam int WATCHDOG_NS  = (TOTAL_CYCLES + 200) * CLK_PERIOD;

    logic               clk;
    logic               rst_i;
    mem_req_t           req;
    logic [`ADDR_W-1:0] load_data_o;
    logic               hit_o;

    logic [`ADDR_W-1:0] ram_model [`RAM_WORDS];  // mirrors the data ram
    logic               tag_valid [LINES];       // per-set valid bit
    logic [TAG_W-1:0]   tag_table [LINES];       // per-set tag
    int                 errors;
    int                 checks;
    int                 tests_run;

    tb_clock #(.PERIOD_NS(CLK_PERIOD)) u_clock (.clk_o(clk));

    mem_stage u_mem_stage (
        .clk         (clk),
        .rst_i       (rst_i),
        .req_i       (req),
        .load_data_o (load_data_o),
        .hit_o       (hit_o)
    );

    task automatic check_data(input logic [`ADDR_W-1:0] act, input logic [`ADDR_W-1:0] exp,
                              input string what);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("** Error at %0t ns: %s data %08h, expected %08h", $time, what, act, exp);
        end
    endtask

    task automatic check_hit(input logic act, input logic exp, input string what);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("** Error at %0t ns: %s hit %b, expected %b", $time, what, act, exp);
        end
    endtask

    // lb/lh sign-extend, lbu/lhu zero-extend, lw as is
    function automatic logic [`ADDR_W-1:0] expected_load(input logic [`ADDR_W-1:0] word,
                                                         input mem_width_e width,
                                                         input logic [1:0] off);
        logic [7:0]  b;
        logic [15:0] h;
        b = 8'(word >> (8 * off));
        h = 16'(word >> (16 * off[1]));
        case (width)
            W_BYTE:  return {{24{b[7]}}, b};
            W_BYTEU: return {24'h0, b};
            W_HALF:  return {{16{h[15]}}, h};
            W_HALFU: return {16'h0, h};
            default: return word;
        endcase
    endfunction

    // bytes of a store land in the lanes picked by the offset
    function automatic logic [`ADDR_W-1:0] merge_store(input logic [`ADDR_W-1:0] old,
                                                       input mem_width_e width,
                                                       input logic [1:0] off,
                                                       input logic [`ADDR_W-1:0] data);
        logic [`ADDR_W-1:0] res;
        res = old;
        case (width)
            W_BYTE, W_BYTEU: res[8 * off +: 8] = data[7:0];
            W_HALF, W_HALFU: res[16 * off[1] +: 16] = data[15:0];
            default:         res = data;
        endcase
        return res;
    endfunction

    function automatic logic [`ADDR_W-1:0] align_addr(input logic [`ADDR_W-1:0] addr,
                                                      input mem_width_e width);
        case (width)
            W_WORD:         return addr & ~32'h3;
            W_HALF, W_HALFU: return addr & ~32'h1;
            default:        return addr;
        endcase
    endfunction

    function automatic mem_width_e rand_width();
        case ($urandom % 5)
            0:       return W_BYTE;
            1:       return W_BYTEU;
            2:       return W_HALF;
            3:       return W_HALFU;
            default: return W_WORD;
        endcase
    endfunction

    // state that reset leaves behind
    task automatic clear_model();
        for (int i = 0; i < `RAM_WORDS; i++) begin
            ram_model[i] = '0;                         // reset zeroes the ram
        end
        for (int s = 0; s < LINES; s++) begin
            tag_valid[s] = 1'b0;
            tag_table[s] = '0;
        end
    endtask

    // one request for one cycle, checked on the falling edge, then the model steps
    task automatic access(input logic we, input mem_width_e width,
                          input logic [`ADDR_W-1:0] addr, input logic [`ADDR_W-1:0] wdata);
        mem_req_t                r;
        logic [`SET_BITS-1:0]    set;
        logic [TAG_W-1:0]        tag;
        logic [IDX_W-1:0]        widx;
        logic                    line_match;
        logic [`ADDR_W-1:0]      exp_data;
        string                   what;
        r.en       = 1'b1;
        r.we       = we;
        r.width    = width;
        r.addr     = addr;
        r.wdata    = wdata;
        set        = addr[`SET_BITS+1:2];
        tag        = addr[`ADDR_W-1:`SET_BITS+2];
        widx       = addr[IDX_W+1:2];
        line_match = tag_valid[set] && (tag_table[set] == tag);
        exp_data   = we ? '0 : expected_load(ram_model[widx], width, addr[1:0]); // stores read 0
        what       = $sformatf("%s %s at %08h", we ? "store" : "load", width.name(), addr);
        @(posedge clk);
        req <= r;
        @(negedge clk);
        check_data(load_data_o, exp_data, what);
        check_hit(hit_o, !we && line_match, what);
        if (we) begin
            ram_model[widx] = merge_store(ram_model[widx], width, addr[1:0], wdata);
            if (!line_match && width == W_WORD) begin
                tag_valid[set] = 1'b1;                 // sw miss allocates
                tag_table[set] = tag;
            end
        end else if (!line_match) begin
            tag_valid[set] = 1'b1;                     // load miss fills
            tag_table[set] = tag;
        end
    endtask

    task automatic idle_cycle();
        @(posedge clk);
        req <= '0;
        @(negedge clk);
        check_data(load_data_o, '0, "idle cycle");
        check_hit(hit_o, 1'b0, "idle cycle");
    endtask

    task automatic finish_test(input string name, input int errs_before);
        tests_run++;
        if (errors == errs_before) begin
            $display("test %-24s ok", name);
        end else begin
            $display("test %-24s FAILED with %0d errors", name, errors - errs_before);
        end
    endtask

    task automatic load_all(input logic [`ADDR_W-1:0] a);
        access(1'b0, W_BYTE,  a, '0);
        access(1'b0, W_BYTEU, a, '0);
        access(1'b0, W_HALF,  a & ~32'h1, '0);
        access(1'b0, W_HALFU, a & ~32'h1, '0);
        access(1'b0, W_WORD,  a & ~32'h3, '0);
    endtask

    task automatic test_after_reset();
        int                 e0;
        mem_width_e         w;
        logic [`ADDR_W-1:0] a;
        e0 = errors;
        for (int i = 0; i < T1_LOADS; i++) begin
            w = rand_width();
            a = 32'(i * 32 + (i % LINES) * 4);       // tag i, set i mod 8
            access(1'b0, w, align_addr(a, w), '0);
        end
        finish_test("after reset", e0);
    endtask

    task automatic test_word_store();
        int                 e0;
        logic [`ADDR_W-1:0] a;
        e0 = errors;
        for (int i = 0; i < T2_WORDS; i++) begin
            a = 32'h200 + 32'(i * 4);
            access(1'b1, W_WORD, a, $urandom);
            access(1'b0, W_WORD, a, '0);
            access(1'b0, W_WORD, a, '0);
        end
        finish_test("word store then load", e0);
    endtask

    task automatic test_partial();
        int e0;
        e0 = errors;
        for (int off = 0; off < 4; off++) begin
            access(1'b1, W_WORD, 32'h140, 32'h1234_5678);
            access(1'b1, W_BYTE, 32'h140 + 32'(off), 32'h0000_00f0 + 32'(off)); // msb set
            load_all(32'h140 + 32'(off));
        end
        for (int h = 0; h < 2; h++) begin
            access(1'b1, W_WORD, 32'h180, 32'h0bad_cafe);
            access(1'b1, W_HALF, 32'h180 + 32'(2 * h), 32'h0000_8a5c + 32'(h));
            load_all(32'h180 + 32'(2 * h));
        end
        finish_test("partial stores", e0);
    endtask

    task automatic test_conflict();
        int e0;
        e0 = errors;
        for (int i = 0; i < T4_ROUNDS; i++) begin
            access(1'b1, W_WORD, 32'h064, $urandom); // both map to set 1
            access(1'b0, W_WORD, 32'h064, '0);
            access(1'b0, W_WORD, 32'h164, '0);         // evicts the other tag
            access(1'b0, W_WORD, 32'h064, '0);
            access(1'b1, W_HALF, 32'h166, $urandom);   // partial miss, no allocate
            access(1'b0, W_WORD, 32'h164, '0);
        end
        finish_test("conflicting tags", e0);
    endtask

    task automatic test_random();
        int                 e0;
        logic               we;
        mem_width_e         w;
        logic [`ADDR_W-1:0] a;
        e0 = errors;
        for (int i = 0; i < T5_ACCESSES; i++) begin
            we = 1'($urandom & 1);
            w  = rand_width();
            a  = ($urandom & 1) ? ($urandom % 1024) : ($urandom % 128); // small window for hits
            access(we, w, align_addr(a, w), $urandom);
        end
        finish_test("seeded random", e0);
    endtask

    // reset raised while a cached, nonzero word is being loaded
    task automatic test_reset_outputs();
        int       e0;
        mem_req_t r;
        e0 = errors;
        access(1'b1, W_WORD, 32'h0c0, 32'hfeed_c0de);  // line valid before reset
        r       = '0;
        r.en    = 1'b1;
        r.width = W_WORD;
        r.addr  = 32'h0c0;
        for (int i = 0; i < RESET_CYCLES; i++) begin
            @(posedge clk);
            rst_i <= 1'b1;
            req   <= r;
            @(negedge clk);
            check_data(load_data_o, '0, "load in reset");
            check_hit(hit_o, 1'b0, "load in reset");
        end
        @(posedge clk);
        rst_i <= 1'b0;
        req   <= '0;
        clear_model();
        access(1'b0, W_WORD, 32'h0c0, '0);             // line and ram word cleared
        finish_test("reset during loads", e0);
    endtask

    initial begin
        void'($urandom(32'h3ead9e2a));
        rst_i     = 1'b1;
        req       = '0;
        errors    = 0;
        checks    = 0;
        tests_run = 0;
        clear_model();
        repeat (RESET_CYCLES) @(posedge clk);
        rst_i <= 1'b0;
        idle_cycle();
        test_after_reset();
        test_word_store();
        test_partial();
        test_conflict();
        test_random();
        test_reset_outputs();
        idle_cycle();
        $display("tests run %0d, checks %0d, errors %0d", tests_run, checks, errors);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    // limit derived from the cycle count of all tests plus margin
    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired at %0t ns, the run timed out", $time);
        $display("Simulation failed");
        $finish;
    end

endmodule

/* files.f */
+incdir+src
src/mem_pkg.sv
src/store_align.sv
src/dcache.sv
src/data_ram.sv
src/load_extend.sv
src/mem_stage.sv
tb/tb_clock.sv
tb/mem_stage_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the mem_stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
SIM_BIN=mem_stage_sim
LOG=sim.log

verilator --binary --timing \
    --top-module mem_stage_tb \
    --Mdir "$BUILD_DIR" \
    -o "$SIM_BIN" \
    -f files.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

"./$BUILD_DIR/$SIM_BIN" > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -qx "Simulation passed" "$LOG"; then
    echo "run passed"
    exit 0
else
    echo "run failed, see $LOG"
    exit 1
fi
